//--- logic/uartPkg.sv
// Shared UART line configuration types, receive structs, timing constants and parity helpers
`default_nettype none

package uartPkg;

   ////////////////////
   // Bit timing
   ////////////////////

   // Clocks between baud enables
   localparam integer BAUD_DIVISOR = 4;
   // Enables per serial bit
   localparam integer SAMPLES_PER_BIT = 16;
   // Start edge to start-bit check
   localparam integer MID_SAMPLE = 8;
   localparam integer BAUD_WIDTH = $clog2(BAUD_DIVISOR);
   localparam integer SAMPLE_WIDTH = $clog2(SAMPLES_PER_BIT);
   // Widest character
   localparam integer CHAR_WIDTH = 8;

   typedef logic [BAUD_WIDTH-1:0] baudCount;
   typedef logic [SAMPLE_WIDTH-1:0] sampleCount;

   ////////////////////
   // Line configuration
   ////////////////////

   // Data bits per character, LSB first on the wire
   typedef enum logic [1:0] {LEN5, LEN6, LEN7, LEN8} charLength;
   // Code 3 behaves like no parity
   typedef enum logic [1:0] {PAR_NONE, PAR_EVEN, PAR_ODD, PAR_RSVD} parityMode;
   typedef enum logic {STOP1, STOP2} stopBits;

   typedef struct packed {
      charLength length;
      parityMode parity;
      stopBits   stop;
   } lineConfig;

   // Configuration after reset or clear, 8N1
   localparam lineConfig DEFAULT_CFG = '{length: LEN8, parity: PAR_NONE, stop: STOP1};

   // Received character, high data bits zero for short lengths
   typedef struct packed {
      logic [CHAR_WIDTH-1:0] data;
      logic                  parityError;
      logic                  framingError;
   } rxChar;

   typedef struct packed {
      logic full;
      logic overrun;
      logic txEmpty;
   } rxStatus;

   ////////////////////
   // Helpers
   ////////////////////

   function automatic logic parityEnabled(parityMode mode);
      return (mode == PAR_EVEN) || (mode == PAR_ODD);
   endfunction

   // Even parity bit makes the total count of ones even
   function automatic logic parityBit(logic [CHAR_WIDTH-1:0] data, parityMode mode);
      return (mode == PAR_ODD) ? ~(^data) : ^data;
   endfunction

   // Keeps only the bits that a character of this length sends
   function automatic logic [CHAR_WIDTH-1:0] dataMask(charLength len);
      return 8'hff >> (2'd3 - len);
   endfunction

endpackage

`default_nettype wire

//--- logic/baudGenerator.sv
// Baud-rate generator, divides clk into the sample enable shared by transmitter and receiver
`default_nettype none
`timescale 1ns/1ps

module baudGenerator (
   input  logic clk,
   input  logic rst,
   input  logic clr,
   output logic clken
);

   // Down-counter, one enable per BAUD_DIVISOR clocks
   uartPkg::baudCount count;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         count <= uartPkg::baudCount'(uartPkg::BAUD_DIVISOR - 1);
      // Restart keeps both serial blocks in phase after a clear
      else if (clr)
         count <= uartPkg::baudCount'(uartPkg::BAUD_DIVISOR - 1);
      else if (count == '0)
         count <= uartPkg::baudCount'(uartPkg::BAUD_DIVISOR - 1);
      else
         count <= count - 1'b1;
   end

   // Pulse on terminal count
   assign clken = (count == '0);

endmodule

`default_nettype wire

//--- logic/uartTransmitter.sv
// Unbuffered UART transmitter, serializes one character per txStart with start, parity and stop
`default_nettype none
`timescale 1ns/1ps

module uartTransmitter (
   input  logic               clk,
   input  logic               rst,
   input  logic               clr,
   input  logic               clken,
   input  uartPkg::lineConfig activeCfg,
   input  logic [7:0]         txData,
   input  logic               txStart,
   output logic               txd,
   output logic               empty,
   output logic               done
);

   // One state per bit on the wire
   typedef enum logic [3:0] {
      IDLE, SYNC, START,
      BIT0, BIT1, BIT2, BIT3, BIT4, BIT5, BIT6, BIT7,
      PARITY, STOP1, STOP2, DONE
   } txState;

   txState state;
   txState nextState;
   txState lastData;
   txState afterData;
   // Enables left in the current bit
   uartPkg::sampleCount count;
   logic [7:0] txReg;
   logic [2:0] bitSel;

   ////////////////////
   // Sequencing
   ////////////////////

   // Final data state follows the character length
   assign lastData = txState'(4'(BIT4) + 4'(activeCfg.length));
   assign afterData = uartPkg::parityEnabled(activeCfg.parity) ? PARITY : STOP1;

   // Successor of a bit state at the end of its 16 enables
   always_comb
   begin
      case (state)
         START:
            nextState = BIT0;
         BIT0, BIT1, BIT2, BIT3, BIT4, BIT5, BIT6, BIT7:
            if (state == lastData)
               nextState = afterData;
            else
               nextState = txState'(state + 4'd1);
         PARITY:
            nextState = STOP1;
         // Second stop bit only for STOP2
         STOP1:
            nextState = (activeCfg.stop == uartPkg::STOP2) ? STOP2 : DONE;
         STOP2:
            nextState = DONE;
         default:
            nextState = IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state <= IDLE;
         count <= '0;
      end
      else if (clr)
      begin
         state <= IDLE;
         count <= '0;
      end
      else
      begin
         case (state)
            IDLE:
               if (txStart)
                  state <= SYNC;
            // Align the first bit to an enable
            SYNC:
               if (clken)
               begin
                  count <= uartPkg::sampleCount'(uartPkg::SAMPLES_PER_BIT - 1);
                  state <= START;
               end
            // Interrupt cycle
            DONE:
               state <= IDLE;
            // All bit states count down 16 enables
            default:
               if (clken)
               begin
                  if (count == '0)
                  begin
                     count <= uartPkg::sampleCount'(uartPkg::SAMPLES_PER_BIT - 1);
                     state <= nextState;
                  end
                  else
                     count <= count - 1'b1;
               end
         endcase
      end
   end

   // Character register, unused high bits cleared so parity ignores them
   always_ff @(posedge clk)
   begin
      if ((state == IDLE) && txStart)
         txReg <= txData & uartPkg::dataMask(activeCfg.length);
   end

   ////////////////////
   // Line driver
   ////////////////////

   // Data bit index from the state code
   assign bitSel = 3'(state - BIT0);

   always_comb
   begin
      case (state)
         START:
            txd = 1'b0;
         BIT0, BIT1, BIT2, BIT3, BIT4, BIT5, BIT6, BIT7:
            txd = txReg[bitSel];
         PARITY:
            txd = uartPkg::parityBit(txReg, activeCfg.parity);
         // Mark level in idle, sync, stop and done
         default:
            txd = 1'b1;
      endcase
   end

   // Empty drops in the load cycle itself
   assign empty = (state == IDLE) && !txStart;
   assign done  = (state == DONE);

endmodule

`default_nettype wire

//--- logic/uartReceiver.sv
// Oversampling UART receiver, validates the start bit and samples each bit at its centre
`default_nettype none
`timescale 1ns/1ps

module uartReceiver (
   input  logic               clk,
   input  logic               rst,
   input  logic               clr,
   input  logic               clken,
   input  uartPkg::lineConfig activeCfg,
   input  logic               rxd,
   output uartPkg::rxChar     rxOut,
   output logic               rxDone,
   output logic               rxIdle
);

   typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} rxState;

   rxState state;
   // Enables to the next sample point
   uartPkg::sampleCount count;
   logic [2:0] bitIndex;
   logic [1:0] syncReg;
   logic rxSync;
   logic sample;
   logic lastData;
   logic [7:0] shReg;
   logic parErr;

   ////////////////////
   // Input synchronizer
   ////////////////////

   // Two flops, reset to the mark level
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         syncReg <= 2'b11;
      else
         syncReg <= {syncReg[0], rxd};
   end

   assign rxSync = syncReg[1];

   ////////////////////
   // Bit sequencing
   ////////////////////

   // Sample point is an enable with the count run out
   assign sample   = clken && (count == '0);
   assign lastData = (bitIndex == (3'd4 + 3'(activeCfg.length)));

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state    <= IDLE;
         count    <= '0;
         bitIndex <= '0;
      end
      else if (clr)
      begin
         state    <= IDLE;
         count    <= '0;
         bitIndex <= '0;
      end
      else if (clken)
      begin
         if (count != '0)
            count <= count - 1'b1;
         else
         begin
            case (state)
               // Falling edge, wait half a bit
               IDLE:
                  if (!rxSync)
                  begin
                     count <= uartPkg::sampleCount'(uartPkg::MID_SAMPLE - 1);
                     state <= START;
                  end
               // Line back high at mid-bit is a glitch
               START:
                  if (rxSync)
                     state <= IDLE;
                  else
                  begin
                     count    <= uartPkg::sampleCount'(uartPkg::SAMPLES_PER_BIT - 1);
                     bitIndex <= '0;
                     state    <= DATA;
                  end
               DATA:
               begin
                  count <= uartPkg::sampleCount'(uartPkg::SAMPLES_PER_BIT - 1);
                  if (!lastData)
                     bitIndex <= bitIndex + 1'b1;
                  else if (uartPkg::parityEnabled(activeCfg.parity))
                     state <= PARITY;
                  else
                     state <= STOP;
               end
               PARITY:
               begin
                  count <= uartPkg::sampleCount'(uartPkg::SAMPLES_PER_BIT - 1);
                  state <= STOP;
               end
               // First stop bit only, a second one passes as idle line
               default:
                  state <= IDLE;
            endcase
         end
      end
   end

   ////////////////////
   // Data capture
   ////////////////////

   // Cleared at the start edge so short characters read zero above length
   always_ff @(posedge clk)
   begin
      if (sample)
      begin
         if ((state == IDLE) && !rxSync)
         begin
            shReg  <= '0;
            parErr <= 1'b0;
         end
         else if (state == DATA)
            shReg[bitIndex] <= rxSync;
         else if (state == PARITY)
            parErr <= (rxSync != uartPkg::parityBit(shReg, activeCfg.parity));
      end
   end

   // Character is valid together with rxDone
   always_comb
   begin
      rxOut.data         = shReg;
      rxOut.parityError  = parErr;
      // Stop bit sampled low
      rxOut.framingError = !rxSync;
   end

   assign rxDone = sample && (state == STOP);
   assign rxIdle = (state == IDLE);

endmodule

`default_nettype wire

//--- logic/uartControl.sv
// UART control block, configuration register, receive holding register, status and interrupts
`default_nettype none
`timescale 1ns/1ps

module uartControl (
   input  logic               clk,
   input  logic               rst,
   input  logic               clr,
   input  logic               cfgWrite,
   input  uartPkg::lineConfig cfg,
   input  logic               txLoad,
   input  logic               txEmptyIn,
   input  logic               txDoneIn,
   input  logic               rxIdle,
   input  logic               rxDone,
   input  uartPkg::rxChar     rxIn,
   input  logic               rxRead,
   output uartPkg::lineConfig activeCfg,
   output logic               txStart,
   output uartPkg::rxChar     rxCharOut,
   output uartPkg::rxStatus   status,
   output logic               txIntr,
   output logic               rxIntr
);

   logic full;
   logic overrun;
   logic cfgAccept;
   logic holdLoad;

   ////////////////////
   // Configuration
   ////////////////////

   // Only between frames on both directions
   assign cfgAccept = cfgWrite && txEmptyIn && rxIdle;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         activeCfg <= uartPkg::DEFAULT_CFG;
      else if (clr)
         activeCfg <= uartPkg::DEFAULT_CFG;
      else if (cfgAccept)
         activeCfg <= cfg;
   end

   ////////////////////
   // Receive holding
   ////////////////////

   // New character only into an empty or just-read register
   assign holdLoad = rxDone && (!full || rxRead);

   always_ff @(posedge clk)
   begin
      if (holdLoad)
         rxCharOut <= rxIn;
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         full    <= 1'b0;
         overrun <= 1'b0;
         rxIntr  <= 1'b0;
      end
      else if (clr)
      begin
         full    <= 1'b0;
         overrun <= 1'b0;
         rxIntr  <= 1'b0;
      end
      else
      begin
         // One cycle after each received frame
         rxIntr <= rxDone;
         if (rxDone)
            full <= 1'b1;
         else if (rxRead)
            full <= 1'b0;
         // Lost character, old one kept
         if (rxDone && full && !rxRead)
            overrun <= 1'b1;
         else if (rxRead)
            overrun <= 1'b0;
      end
   end

   ////////////////////
   // Status and transmit
   ////////////////////

   always_comb
   begin
      status.full    = full;
      status.overrun = overrun;
      status.txEmpty = txEmptyIn;
   end

   // Transmitter drops a load while busy
   assign txStart = txLoad;
   assign txIntr  = txDoneIn;

endmodule

`default_nettype wire

//--- logic/uartTop.sv
// Serial port top level, joins control, baud generator, transmitter and receiver
`default_nettype none
`timescale 1ns/1ps

module uartTop (
   input  logic               clk,
   input  logic               rst,
   input  logic               clr,
   input  logic               cfgWrite,
   input  uartPkg::lineConfig cfg,
   input  logic [7:0]         txData,
   input  logic               txLoad,
   input  logic               rxRead,
   input  logic               rxd,
   output logic               txd,
   output uartPkg::rxChar     rxCharOut,
   output uartPkg::rxStatus   status,
   output logic               txIntr,
   output logic               rxIntr
);

   // Shared bit-sample enable
   logic clken;
   uartPkg::lineConfig activeCfg;
   logic txStart;
   logic txEmpty;
   logic txDone;
   // Receiver to control
   uartPkg::rxChar rxChar;
   logic rxDone;
   logic rxIdle;

   baudGenerator baudGen (
      .clk   (clk),
      .rst   (rst),
      .clr   (clr),
      .clken (clken)
   );

   uartTransmitter transmitter (
      .clk       (clk),
      .rst       (rst),
      .clr       (clr),
      .clken     (clken),
      .activeCfg (activeCfg),
      .txData    (txData),
      .txStart   (txStart),
      .txd       (txd),
      .empty     (txEmpty),
      .done      (txDone)
   );

   uartReceiver receiver (
      .clk       (clk),
      .rst       (rst),
      .clr       (clr),
      .clken     (clken),
      .activeCfg (activeCfg),
      .rxd       (rxd),
      .rxOut     (rxChar),
      .rxDone    (rxDone),
      .rxIdle    (rxIdle)
   );

   uartControl control (
      .clk       (clk),
      .rst       (rst),
      .clr       (clr),
      .cfgWrite  (cfgWrite),
      .cfg       (cfg),
      .txLoad    (txLoad),
      .txEmptyIn (txEmpty),
      .txDoneIn  (txDone),
      .rxIdle    (rxIdle),
      .rxDone    (rxDone),
      .rxIn      (rxChar),
      .rxRead    (rxRead),
      .activeCfg (activeCfg),
      .txStart   (txStart),
      .rxCharOut (rxCharOut),
      .status    (status),
      .txIntr    (txIntr),
      .rxIntr    (rxIntr)
   );

endmodule

`default_nettype wire

//--- verification/uartTb.sv
// Directed testbench for the serial port driving uartTop through loopback and hand-built frames
`default_nettype none
`timescale 1ns/1ps

module uartTb;

   logic clk;
   logic rst;
   logic clr;
   logic cfgWrite;
   uartPkg::lineConfig cfg;
   logic [7:0] txData;
   logic txLoad;
   logic rxRead;
   logic txd;
   uartPkg::rxChar rxCharOut;
   uartPkg::rxStatus status;
   logic txIntr;
   logic rxIntr;

   // Loopback select with rxd taken from driveFrame when low
   logic loopback;
   logic tbRxd;
   logic rxdLine;
   integer seed;
   int waitLimit = 2000;
   int cycle;
   int txCount;
   int rxCount;

   assign rxdLine = loopback ? txd : tbRxd;

   uartTop DUT (
      .clk       (clk),
      .rst       (rst),
      .clr       (clr),
      .cfgWrite  (cfgWrite),
      .cfg       (cfg),
      .txData    (txData),
      .txLoad    (txLoad),
      .rxRead    (rxRead),
      .rxd       (rxdLine),
      .txd       (txd),
      .rxCharOut (rxCharOut),
      .status    (status),
      .txIntr    (txIntr),
      .rxIntr    (rxIntr)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Cycle and interrupt pulse counters
   always @(posedge clk)
   begin
      cycle <= cycle + 1;
      if (rst)
      begin
         txCount <= 0;
         rxCount <= 0;
      end
      else
      begin
         if (txIntr)
            txCount <= txCount + 1;
         if (rxIntr)
            rxCount <= rxCount + 1;
      end
   end

   ////////////////////
   // Helpers
   ////////////////////

   // Step to 1 ns after the next rising edge
   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic stopOnError(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1, "stopping at first error");
   endtask

   function automatic uartPkg::lineConfig makeConfig(input uartPkg::charLength len,
                                                     input uartPkg::parityMode par,
                                                     input uartPkg::stopBits stop);
      uartPkg::lineConfig result;
      result.length = len;
      result.parity = par;
      result.stop = stop;
      return result;
   endfunction

   function automatic uartPkg::rxChar makeChar(input logic [7:0] data, input logic parErr,
                                               input logic frameErr);
      uartPkg::rxChar result;
      result.data = data;
      result.parityError = parErr;
      result.framingError = frameErr;
      return result;
   endfunction

   function automatic uartPkg::rxStatus makeStatus(input logic full, input logic overrun,
                                                   input logic txEmpty);
      uartPkg::rxStatus result;
      result.full = full;
      result.overrun = overrun;
      result.txEmpty = txEmpty;
      return result;
   endfunction

   // Low bits a character of this length carries
   function automatic logic [7:0] keepLow(input logic [7:0] data, input uartPkg::charLength len);
      logic [7:0] result;
      result = '0;
      for (int i = 0; i < 5 + int'(len); i++)
         result[i] = data[i];
      return result;
   endfunction

   // Ones in data plus parity bit are even for PAR_EVEN and odd for PAR_ODD
   function automatic logic expectedParity(input logic [7:0] data, input uartPkg::parityMode mode);
      int ones;
      ones = 0;
      for (int i = 0; i < 8; i++)
         ones += data[i];
      if (mode == uartPkg::PAR_ODD)
         return (ones % 2) == 0;
      else
         return (ones % 2) == 1;
   endfunction

   // Only even and odd put a parity bit on the wire
   function automatic logic parityOn(input uartPkg::parityMode mode);
      logic result;
      case (mode)
         uartPkg::PAR_EVEN, uartPkg::PAR_ODD:
            result = 1'b1;
         default:
            result = 1'b0;
      endcase
      return result;
   endfunction

   ////////////////////
   // Compare tasks
   ////////////////////

   task automatic checkChar(input string name, input uartPkg::rxChar expected,
                            input uartPkg::rxChar actual);
      if (actual !== expected)
         stopOnError($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
   endtask

   task automatic checkStatus(input string name, input uartPkg::rxStatus expected,
                              input uartPkg::rxStatus actual);
      if (actual !== expected)
         stopOnError($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
   endtask

   task automatic checkBit(input string name, input logic expected, input logic actual);
      if (actual !== expected)
         stopOnError($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
   endtask

   ////////////////////
   // Bounded waits
   ////////////////////

   task automatic waitTxEmpty();
      int n;
      n = 0;
      while (!status.txEmpty)
      begin
         if (n == waitLimit)
            stopOnError("timeout waiting for status.txEmpty");
         tick();
         n++;
      end
   endtask

   task automatic waitTxIntr(input int target);
      int n;
      n = 0;
      while (txCount < target)
      begin
         if (n == waitLimit)
            stopOnError("timeout waiting for txIntr");
         tick();
         n++;
      end
   endtask

   task automatic waitFull();
      int n;
      n = 0;
      while (!status.full)
      begin
         if (n == waitLimit)
            stopOnError("timeout waiting for status.full");
         tick();
         n++;
      end
   endtask

   // Start bit on txd
   task automatic waitTxdLow();
      int n;
      n = 0;
      while (txd)
      begin
         if (n == waitLimit)
            stopOnError("timeout waiting for a start bit on txd");
         tick();
         n++;
      end
   endtask

   ////////////////////
   // Stimulus tasks
   ////////////////////

   // Ignored by the DUT unless both directions are idle
   task automatic writeConfig(input uartPkg::lineConfig newCfg);
      cfg = newCfg;
      cfgWrite = 1'b1;
      tick();
      cfgWrite = 1'b0;
   endtask

   task automatic sendChar(input logic [7:0] data);
      waitTxEmpty();
      txData = data;
      txLoad = 1'b1;
      tick();
      txLoad = 1'b0;
   endtask

   task automatic readChar();
      rxRead = 1'b1;
      tick();
      rxRead = 1'b0;
   endtask

   // One bit time on the testbench rxd
   task automatic holdLine(input logic level);
      tbRxd = level;
      repeat (uartPkg::BAUD_DIVISOR * uartPkg::SAMPLES_PER_BIT) tick();
   endtask

   task automatic driveFrame(input logic [7:0] data, input uartPkg::lineConfig frameCfg,
                             input logic flipParity, input logic lowStop);
      int nData;
      nData = 5 + int'(frameCfg.length);
      holdLine(1'b0);
      for (int i = 0; i < nData; i++)
         holdLine(data[i]);
      if (parityOn(frameCfg.parity))
         holdLine(expectedParity(keepLow(data, frameCfg.length), frameCfg.parity) ^ flipParity);
      holdLine(!lowStop);
      if (frameCfg.stop == uartPkg::STOP2)
         holdLine(1'b1);
      // Idle gap so the receiver settles
      holdLine(1'b1);
      holdLine(1'b1);
   endtask

   // Samples txd at bit centres and checks frame length via txIntr timing
   task automatic watchFrame(input logic [7:0] data, input uartPkg::lineConfig frameCfg);
      int nData;
      int nBits;
      int target;
      int startCycle;
      int elapsed;
      logic [7:0] expData;
      nData = 5 + int'(frameCfg.length);
      nBits = 2 + nData + parityOn(frameCfg.parity) + (frameCfg.stop == uartPkg::STOP2);
      expData = keepLow(data, frameCfg.length);
      target = txCount + 1;
      waitTxdLow();
      startCycle = cycle;
      repeat (32) tick();
      checkBit("txd start bit", 1'b0, txd);
      for (int i = 0; i < nData; i++)
      begin
         repeat (64) tick();
         checkBit($sformatf("txd data bit %0d", i), expData[i], txd);
      end
      if (parityOn(frameCfg.parity))
      begin
         repeat (64) tick();
         checkBit("txd parity bit", expectedParity(expData, frameCfg.parity), txd);
      end
      repeat (64) tick();
      checkBit("txd stop bit", 1'b1, txd);
      if (frameCfg.stop == uartPkg::STOP2)
      begin
         repeat (64) tick();
         checkBit("txd second stop bit", 1'b1, txd);
      end
      waitTxIntr(target);
      elapsed = cycle - startCycle;
      if ((elapsed < nBits * 64) || (elapsed > nBits * 64 + 2))
         stopOnError($sformatf("frame took %0d clocks, %0d bits expected", elapsed, nBits));
   endtask

   ////////////////////
   // Directed tests
   ////////////////////

   task automatic testDefaultLoopback();
      logic [7:0] b;
      int txBase;
      int rxBase;
      txBase = txCount;
      rxBase = rxCount;
      for (int i = 0; i < 10; i++)
      begin
         b = $random(seed);
         sendChar(b);
         waitTxIntr(txCount + 1);
         waitFull();
         if ((txCount != txBase + i + 1) || (rxCount != rxBase + i + 1))
            stopOnError("interrupt pulses do not match one per byte");
         checkStatus("status", makeStatus(1'b1, 1'b0, 1'b1), status);
         checkChar("rxCharOut", makeChar(b, 1'b0, 1'b0), rxCharOut);
         readChar();
         checkStatus("status", makeStatus(1'b0, 1'b0, 1'b1), status);
      end
   endtask

   task automatic configLoopback(input uartPkg::lineConfig frameCfg);
      logic [7:0] b;
      writeConfig(frameCfg);
      b = $random(seed);
      sendChar(b);
      watchFrame(b, frameCfg);
      waitFull();
      checkChar("rxCharOut", makeChar(keepLow(b, frameCfg.length), 1'b0, 1'b0), rxCharOut);
      readChar();
   endtask

   task automatic testErrors();
      uartPkg::lineConfig frameCfg;
      frameCfg = makeConfig(uartPkg::LEN8, uartPkg::PAR_EVEN, uartPkg::STOP1);
      writeConfig(frameCfg);
      loopback = 1'b0;
      driveFrame(8'h96, frameCfg, 1'b1, 1'b0);
      waitFull();
      checkChar("rxCharOut", makeChar(8'h96, 1'b1, 1'b0), rxCharOut);
      readChar();
      driveFrame(8'h4b, frameCfg, 1'b0, 1'b1);
      waitFull();
      checkChar("rxCharOut", makeChar(8'h4b, 1'b0, 1'b1), rxCharOut);
      readChar();
      loopback = 1'b1;
   endtask

   // Second character lost and first one kept
   task automatic testOverrun();
      sendChar(8'h11);
      waitTxIntr(txCount + 1);
      sendChar(8'hee);
      waitTxIntr(txCount + 1);
      checkStatus("status", makeStatus(1'b1, 1'b1, 1'b1), status);
      checkChar("rxCharOut", makeChar(8'h11, 1'b0, 1'b0), rxCharOut);
      readChar();
      checkStatus("status", makeStatus(1'b0, 1'b0, 1'b1), status);
   endtask

   task automatic testBusyRules();
      uartPkg::lineConfig plain;
      int target;
      plain = makeConfig(uartPkg::LEN8, uartPkg::PAR_NONE, uartPkg::STOP1);
      writeConfig(plain);
      // Load while busy is dropped
      sendChar(8'h3c);
      repeat (100) tick();
      checkBit("status.txEmpty", 1'b0, status.txEmpty);
      txData = 8'hc3;
      txLoad = 1'b1;
      tick();
      txLoad = 1'b0;
      waitTxIntr(txCount + 1);
      waitFull();
      checkChar("rxCharOut", makeChar(8'h3c, 1'b0, 1'b0), rxCharOut);
      readChar();
      // Config write in mid-frame leaves the next frame at 8 bits
      sendChar(8'ha5);
      repeat (100) tick();
      writeConfig(makeConfig(uartPkg::LEN5, uartPkg::PAR_NONE, uartPkg::STOP1));
      waitTxIntr(txCount + 1);
      waitFull();
      readChar();
      sendChar(8'he7);
      watchFrame(8'he7, plain);
      waitFull();
      checkChar("rxCharOut", makeChar(8'he7, 1'b0, 1'b0), rxCharOut);
      readChar();
      // Clear in mid-frame
      sendChar(8'h5a);
      repeat (100) tick();
      target = txCount;
      clr = 1'b1;
      tick();
      clr = 1'b0;
      checkBit("txd", 1'b1, txd);
      checkBit("status.txEmpty", 1'b1, status.txEmpty);
      repeat (1000) tick();
      if (txCount != target)
         stopOnError("txIntr pulsed after a mid-frame clear");
      checkStatus("status", makeStatus(1'b0, 1'b0, 1'b1), status);
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial
   begin
      seed = 32'hb402_83ec;
      rst = 1'b1;
      clr = 1'b0;
      cfgWrite = 1'b0;
      cfg = makeConfig(uartPkg::LEN8, uartPkg::PAR_NONE, uartPkg::STOP1);
      txData = 8'h00;
      txLoad = 1'b0;
      rxRead = 1'b0;
      tbRxd = 1'b1;
      loopback = 1'b1;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      tick();
      checkBit("txd", 1'b1, txd);
      checkBit("txIntr", 1'b0, txIntr);
      checkBit("rxIntr", 1'b0, rxIntr);
      checkStatus("status", makeStatus(1'b0, 1'b0, 1'b1), status);

      testDefaultLoopback();
      configLoopback(makeConfig(uartPkg::LEN5, uartPkg::PAR_EVEN, uartPkg::STOP1));
      configLoopback(makeConfig(uartPkg::LEN6, uartPkg::PAR_ODD, uartPkg::STOP1));
      configLoopback(makeConfig(uartPkg::LEN7, uartPkg::PAR_NONE, uartPkg::STOP2));
      testErrors();
      testOverrun();
      testBusyRules();

      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
logic/uartPkg.sv
logic/baudGenerator.sv
logic/uartTransmitter.sv
logic/uartReceiver.sv
logic/uartControl.sv
logic/uartTop.sv
verification/uartTb.sv
